//--- design/arith_pkg.sv
`default_nettype none

package arith_pkg;

    // Datapath is a single word
    localparam int WORD_W = 32;

    // Enough to index every bit of a word
    localparam int BIT_CNT_W = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    // n = 251 * 257 = 64507, all arithmetic runs modulo n squared
    localparam word_t MODULUS_N2 = 32'd4161153049;

endpackage

`default_nettype wire

//--- design/task_pkg.sv
`default_nettype none

package task_pkg;

    // Ciphertext-domain tasks
    typedef enum logic [0:0] {
        CMD_HOMO_ADD   = 1'b0,
        CMD_SCALAR_MUL = 1'b1
    } task_cmd_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_END
    } seq_state_t;

    // SQUARE and MULT each last one cycle and issue one product
    typedef enum logic [2:0] {
        EXP_IDLE,
        EXP_SQUARE,
        EXP_MULT,
        EXP_WAIT,
        EXP_DONE
    } exp_state_t;

endpackage

`default_nettype wire

//--- design/mult_if.sv
`default_nettype none

interface mult_if;
    import arith_pkg::*;

    logic  start;
    word_t x;
    word_t y;
    word_t product;
    logic  done;

    // Requester side
    modport req (output start, x, y, input product, done);

    // Multiplier side
    modport calc (input start, x, y, output product, done);

endinterface

`default_nettype wire

//--- design/arith_if.sv
`default_nettype none

interface arith_if;
    import arith_pkg::*;
    import task_pkg::*;

    task_cmd_t op;
    word_t     base;
    word_t     arg;
    logic      start;
    word_t     result;
    logic      done;

    // Task sequencer side
    modport seq (output op, base, arg, start, input result, done);

    // Exponent unit side
    modport exp (input op, base, arg, start, output result, done);

endinterface

`default_nettype wire

//--- design/mod_mult.sv
`default_nettype none

module mod_mult (
    input logic  clk,
    input logic  rst_n,
    mult_if.calc mult
);
    import arith_pkg::*;

    word_t             x_q;
    word_t             y_q;
    word_t             acc;
    bit_cnt_t          bit_idx;
    logic              running;
    logic [WORD_W+1:0] sum;
    logic [WORD_W+1:0] red1;
    logic [WORD_W+1:0] red2;

    // Double, add y on a set bit, then bring back below the modulus
    always_comb begin
        sum = {1'b0, acc, 1'b0} + (x_q[WORD_W-1] ? {2'b00, y_q} : '0);
        if (sum >= {2'b00, MODULUS_N2}) begin
            red1 = sum - {2'b00, MODULUS_N2};
        end else begin
            red1 = sum;
        end
        if (red1 >= {2'b00, MODULUS_N2}) begin
            red2 = red1 - {2'b00, MODULUS_N2};
        end else begin
            red2 = red1;
        end
    end

    // One bit of x per cycle, 32 steps after the start edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            bit_idx   <= '0;
            mult.done <= 1'b0;
        end else begin
            mult.done <= 1'b0;
            if (mult.start) begin
                running <= 1'b1;
                bit_idx <= '1;
            end else if (running) begin
                if (bit_idx == '0) begin
                    running   <= 1'b0;
                    mult.done <= 1'b1;
                end
                bit_idx <= bit_idx - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mult.start) begin
            x_q <= mult.x;
            y_q <= mult.y;
            acc <= '0;
        end else if (running) begin
            x_q <= x_q << 1;
            acc <= red2[WORD_W-1:0];
            if (bit_idx == '0) begin
                mult.product <= red2[WORD_W-1:0];
            end
        end
    end

    product_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        mult.done |-> (mult.product < MODULUS_N2));

endmodule

`default_nettype wire

//--- design/mod_exp_unit.sv
`default_nettype none

module mod_exp_unit (
    input logic  clk,
    input logic  rst_n,
    arith_if.exp arith,
    mult_if.req  mult
);
    import arith_pkg::*;
    import task_pkg::*;

    exp_state_t state;
    task_cmd_t  op_q;
    word_t      base_q;
    word_t      acc;
    word_t      exp_bits;
    bit_cnt_t   bit_idx;
    logic       sq_phase;
    logic       take_mult;

    // A square just finished on a set exponent bit
    assign take_mult = sq_phase && exp_bits[WORD_W-1];

    assign mult.start = (state == EXP_SQUARE) || (state == EXP_MULT);
    assign mult.x = acc;
    assign mult.y = (state == EXP_SQUARE) ? acc : base_q;

    assign arith.result = acc;
    assign arith.done = (state == EXP_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EXP_IDLE;
            sq_phase <= 1'b0;
            bit_idx  <= '0;
        end else begin
            case (state)
                EXP_IDLE: begin
                    if (arith.start) begin
                        bit_idx  <= '1;
                        sq_phase <= 1'b0;
                        if (arith.op == CMD_SCALAR_MUL) begin
                            state <= EXP_SQUARE;
                        end else begin
                            state <= EXP_MULT;
                        end
                    end
                end
                EXP_SQUARE: begin
                    sq_phase <= 1'b1;
                    state    <= EXP_WAIT;
                end
                EXP_MULT: begin
                    sq_phase <= 1'b0;
                    state    <= EXP_WAIT;
                end
                EXP_WAIT: begin
                    if (mult.done) begin
                        if (op_q == CMD_HOMO_ADD) begin
                            state <= EXP_DONE;
                        end else if (take_mult) begin
                            state <= EXP_MULT;
                        end else if (bit_idx == '0) begin
                            state <= EXP_DONE;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            state   <= EXP_SQUARE;
                        end
                    end
                end
                EXP_DONE: state <= EXP_IDLE;
                default:  state <= EXP_IDLE;
            endcase
        end
    end

    // Scalar multiply starts from 1, a plain product from the second operand
    always_ff @(posedge clk) begin
        if (state == EXP_IDLE && arith.start) begin
            op_q     <= arith.op;
            base_q   <= arith.base;
            exp_bits <= arith.arg;
            acc      <= (arith.op == CMD_SCALAR_MUL) ? word_t'(1) : arith.arg;
        end else if (state == EXP_WAIT && mult.done) begin
            acc <= mult.product;
            if (!take_mult) begin
                exp_bits <= exp_bits << 1;
            end
        end
    end

    // A product stays pending for the full multiplier latency
    no_overlapping_product: assert property (@(posedge clk) disable iff (!rst_n)
        mult.start |=> !mult.start [*WORD_W + 1]);

endmodule

`default_nettype wire

//--- design/task_sequencer.sv
`default_nettype none

module task_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                task_req,
    input  task_pkg::task_cmd_t task_cmd,
    input  arith_pkg::word_t    op_a,
    input  arith_pkg::word_t    op_b,
    output logic                busy,
    output logic                task_end,
    output arith_pkg::word_t    result,
    arith_if.seq                arith
);
    import arith_pkg::*;
    import task_pkg::*;

    seq_state_t state;
    task_cmd_t  cmd_q;
    word_t      a_q;
    word_t      b_q;
    logic       start_q;
    logic       accept;

    // Busy drops together with task_end
    assign busy = (state == SEQ_RUN);
    assign task_end = (state == SEQ_END);
    assign accept = task_req && !busy;

    assign arith.start = start_q;
    assign arith.op = cmd_q;
    assign arith.base = a_q;
    assign arith.arg = b_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            start_q <= 1'b0;
            result  <= '0;
        end else begin
            start_q <= accept;
            case (state)
                // A new request may also land in the end cycle
                SEQ_IDLE, SEQ_END: begin
                    if (accept) begin
                        state <= SEQ_RUN;
                    end else begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_RUN: begin
                    if (arith.done) begin
                        result <= arith.result;
                        state  <= SEQ_END;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= task_cmd;
            a_q   <= op_a;
            b_q   <= op_b;
        end
    end

    // The multiplier expects its y operand below n squared
    operand_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (op_a < MODULUS_N2) && (task_cmd != CMD_HOMO_ADD || op_b < MODULUS_N2));

endmodule

`default_nettype wire

//--- design/paillier_top.sv
`default_nettype none

module paillier_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                task_req,
    input  task_pkg::task_cmd_t task_cmd,
    input  arith_pkg::word_t    op_a,
    input  arith_pkg::word_t    op_b,
    output logic                busy,
    output logic                task_end,
    output arith_pkg::word_t    result
);

    arith_if arith_bus ();
    mult_if  mult_bus ();

    task_sequencer i_task_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .task_req (task_req),
        .task_cmd (task_cmd),
        .op_a     (op_a),
        .op_b     (op_b),
        .busy     (busy),
        .task_end (task_end),
        .result   (result),
        .arith    (arith_bus.seq)
    );

    // Plain product or square-and-multiply
    mod_exp_unit i_mod_exp_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .arith (arith_bus.exp),
        .mult  (mult_bus.req)
    );

    // Shared serial multiplier
    mod_mult i_mod_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .mult  (mult_bus.calc)
    );

endmodule

`default_nettype wire

//--- tests/tb_paillier_top.sv
`default_nettype none

module tb_paillier_top;
    import arith_pkg::*;
    import task_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_COUNT = 40;

    logic      clk;
    logic      rst_n;
    logic      task_req;
    task_cmd_t task_cmd;
    word_t     op_a;
    word_t     op_b;
    logic      busy;
    logic      task_end;
    word_t     result;

    int checks;
    int errors;

    paillier_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .task_req (task_req),
        .task_cmd (task_cmd),
        .op_a     (op_a),
        .op_b     (op_b),
        .busy     (busy),
        .task_end (task_end),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Product of two words reduced modulo n squared
    function automatic word_t ref_mulmod(input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        prod = prod % {32'd0, MODULUS_N2};
        return prod[WORD_W-1:0];
    endfunction

    function automatic word_t ref_powmod(input word_t base, input word_t exponent);
        word_t r;
        r = 32'd1;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            r = ref_mulmod(r, r);
            if (exponent[i]) begin
                r = ref_mulmod(r, base);
            end
        end
        return r;
    endfunction

    // Inputs change and outputs are sampled just after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %s: got %08h expected %08h", name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %s: got %0h expected %0h", name, got, expected);
        end
    endtask

    task automatic wait_task_end(output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < TIMEOUT_CYCLES) begin
            step();
            n++;
            if (task_end) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            errors++;
            $display("No task_end seen within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    task automatic run_task(input task_cmd_t cmd, input word_t a, input word_t b,
                            input word_t expected);
        bit ok;
        task_req = 1'b1;
        task_cmd = cmd;
        op_a = a;
        op_b = b;
        step();
        task_req = 1'b0;
        check_bit("busy", busy, 1'b1);
        wait_task_end(ok);
        if (ok) begin
            check_bit("busy", busy, 1'b0);
            check_word("result", result, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-18s %s", name, (errors == errors_before) ? "passed" : "FAILED");
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit("busy", busy, 1'b0);
        check_bit("task_end", task_end, 1'b0);
        check_word("result", result, '0);
        report_test("reset", e0);
    endtask

    task automatic test_homo_add_corners();
        word_t vals [4];
        int e0;
        e0 = errors;
        vals = '{32'd0, 32'd1, 32'd2, MODULUS_N2 - 1};
        foreach (vals[i]) begin
            foreach (vals[j]) begin
                run_task(CMD_HOMO_ADD, vals[i], vals[j], ref_mulmod(vals[i], vals[j]));
            end
        end
        report_test("homo_add_corners", e0);
    endtask

    task automatic test_scalar_corners();
        word_t bases [4];
        int e0;
        e0 = errors;
        bases = '{32'd0, 32'd2, 32'd1234567, MODULUS_N2 - 1};
        foreach (bases[i]) begin
            run_task(CMD_SCALAR_MUL, bases[i], 32'd0, 32'd1);
            run_task(CMD_SCALAR_MUL, bases[i], 32'd1, bases[i]);
            run_task(CMD_SCALAR_MUL, bases[i], 32'd2, ref_mulmod(bases[i], bases[i]));
            run_task(CMD_SCALAR_MUL, bases[i], 32'hffffffff,
                     ref_powmod(bases[i], 32'hffffffff));
        end
        report_test("scalar_corners", e0);
    endtask

    task automatic test_random_mix();
        task_cmd_t cmd;
        word_t     a;
        word_t     b;
        int        e0;
        e0 = errors;
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            cmd = ($urandom % 2 == 1) ? CMD_SCALAR_MUL : CMD_HOMO_ADD;
            a = $urandom % MODULUS_N2;
            b = $urandom % MODULUS_N2;
            if (cmd == CMD_SCALAR_MUL) begin
                run_task(cmd, a, b, ref_powmod(a, b));
            end else begin
                run_task(cmd, a, b, ref_mulmod(a, b));
            end
        end
        report_test("random_mix", e0);
    endtask

    task automatic test_busy_protocol();
        word_t a1;
        word_t b1;
        bit    ok;
        int    extra_ends;
        int    e0;
        e0 = errors;
        a1 = 32'd98765;
        b1 = 32'd4321;
        task_req = 1'b1;
        task_cmd = CMD_HOMO_ADD;
        op_a = a1;
        op_b = b1;
        step();
        // Second request stays up for the whole run
        task_cmd = CMD_SCALAR_MUL;
        op_a = 32'd7;
        op_b = 32'd5;
        check_bit("busy", busy, 1'b1);
        wait_task_end(ok);
        task_req = 1'b0;
        if (ok) begin
            check_bit("busy", busy, 1'b0);
            check_word("result", result, ref_mulmod(a1, b1));
            extra_ends = 0;
            repeat (40) begin
                step();
                if (task_end) begin
                    extra_ends++;
                end
                check_bit("busy", busy, 1'b0);
            end
            checks++;
            if (extra_ends != 0) begin
                errors++;
                $display("Request held during a busy task was accepted, %0d extra task_end",
                         extra_ends);
            end
            // Nothing from the held request may still run behind a new task
            run_task(CMD_HOMO_ADD, 32'd3, 32'd11, ref_mulmod(32'd3, 32'd11));
        end
        report_test("busy_protocol", e0);
    endtask

    initial begin
        int discard;
        checks = 0;
        errors = 0;
        rst_n = 1'b0;
        task_req = 1'b0;
        task_cmd = CMD_HOMO_ADD;
        op_a = '0;
        op_b = '0;
        discard = $urandom(32'hc8b5);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        test_reset();
        test_homo_add_corners();
        test_scalar_corners();
        test_random_mix();
        test_busy_protocol();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/arith_pkg.sv
design/task_pkg.sv
design/mult_if.sv
design/arith_if.sv
design/mod_mult.sv
design/mod_exp_unit.sv
design/task_sequencer.sv
design/paillier_top.sv
tests/tb_paillier_top.sv

//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module paillier_top

obj_dir/Vtb_paillier_top: build.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -f build.f --top-module tb_paillier_top -Mdir obj_dir

sim: obj_dir/Vtb_paillier_top
	./obj_dir/Vtb_paillier_top > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log
